// ==== rtl/pcie_cq_pkg.sv ====
// completer-request path definitions
// beat, DW and header field widths, request type codes
// header field offsets within the first beat
// packed structs for stream beats, read requests, write events and FIFO words

package pcie_cq_pkg;

   localparam int cq_data_w = 256;
   localparam int dw_w      = 32;
   localparam int half_w    = cq_data_w / 2;  // 128, one header or payload half
   localparam int len_w     = 11;             // DW count field
   localparam int addr_w    = 11;             // DW address kept from a read
   localparam int type_w    = 4;
   localparam int tc_w      = 3;
   localparam int attr_w    = 3;
   localparam int rid_w     = 16;
   localparam int tag_w     = 8;
   localparam int be_w      = 8;

   localparam logic [type_w-1:0] req_type_rd = 4'd0;  // memory read
   localparam logic [type_w-1:0] req_type_wr = 4'd1;  // memory write

   // header fields, lower 128 bits of the first beat
   localparam int addr_lsb = 2;    // DW aligned
   localparam int len_lsb  = 64;
   localparam int type_lsb = 75;
   localparam int rid_lsb  = 80;
   localparam int tag_lsb  = 96;
   localparam int tc_lsb   = 121;
   localparam int attr_lsb = 124;

   localparam logic [len_w-1:0] head_dw = 11'd4;  // payload DWs in the header beat
   localparam logic [len_w-1:0] beat_dw = 11'd8;  // payload DWs in later beats

   typedef struct packed {
      logic [cq_data_w-1:0] data;
      logic                 last;
      logic [be_w-1:0]      first_be;
   } cq_beat_t;

   typedef struct packed {
      logic [tc_w-1:0]   tc;
      logic [attr_w-1:0] attr;
      logic [len_w-1:0]  len;
      logic [rid_w-1:0]  rid;
      logic [tag_w-1:0]  tag;
      logic [be_w-1:0]   be;
      logic [addr_w-1:0] addr;
   } rd_req_t;

   typedef struct packed {
      logic                 start;  // header beat
      logic [len_w-1:0]     len;    // valid with start only
      logic [cq_data_w-1:0] data;
   } wr_evt_t;

   typedef struct packed {
      logic [cq_data_w-1:0] data;
      logic                 last;
   } fifo_word_t;

endpackage

// ==== rtl/rx_monitor_pkg.sv ====
// throughput monitor definitions
// measurement window, counter width, history depth and history type

package rx_monitor_pkg;

   // 100 ms at 250 MHz
   localparam int window_cycles_default = 25_000_000;

   localparam int count_w = 32;     // FIFO words per window
   localparam int hist_depth = 10;  // samples kept

   // entry 0 holds the newest sample
   typedef logic [hist_depth-1:0][count_w-1:0] tp_hist_t;

endpackage

// ==== rtl/cq_request_decoder.sv ====
// completer-request decoder
// start-of-packet tracking on the completer stream
// header decode of type and length
// single-DW read capture, held until the completion side is done
// write beats forwarded to the packer as one-cycle events

`timescale 1ns/100ps

module cq_request_decoder (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cq_valid_i,
   input  pcie_cq_pkg::cq_beat_t cq_beat_i,
   input  logic                  compl_done_i,
   input  logic                  flush_stall_i,
   output logic                  cq_ready_o,
   output logic                  req_compl_o,
   output pcie_cq_pkg::rd_req_t  rd_req_o,
   output logic                  wr_evt_valid_o,
   output pcie_cq_pkg::wr_evt_t  wr_evt_o
);

   typedef enum logic {
      st_idle,
      st_rd_wait     // completion in flight, stream held
   } state_t;

   state_t state_q;
   logic   ready_q;
   logic   in_pkt_q;   // past the header beat
   logic   wr_pkt_q;   // current packet is a write
   logic   drain_q;    // packer still owes a flush word

   logic                           sop;
   logic                           take;
   logic [pcie_cq_pkg::type_w-1:0] hdr_type;
   logic [pcie_cq_pkg::len_w-1:0]  hdr_len;
   logic                           hdr_wr;
   logic                           hdr_rd1;
   logic                           rd_block;
   logic                           rd_hit;
   logic                           wr_beat;

   ////////////////////////////////////////////////////////////////////////////
   // header decode
   ////////////////////////////////////////////////////////////////////////////
   assign sop      = cq_valid_i && !in_pkt_q;
   assign hdr_type = cq_beat_i.data[pcie_cq_pkg::type_lsb +: pcie_cq_pkg::type_w];
   assign hdr_len  = cq_beat_i.data[pcie_cq_pkg::len_lsb +: pcie_cq_pkg::len_w];
   assign hdr_wr   = hdr_type == pcie_cq_pkg::req_type_wr;
   assign hdr_rd1  = (hdr_type == pcie_cq_pkg::req_type_rd) &&
                     (hdr_len == pcie_cq_pkg::len_w'(1));    // only 1 DW reads served

   // a read header waits until the last write word has left the packer
   assign rd_block   = sop && hdr_rd1 && (wr_evt_valid_o || drain_q);
   assign cq_ready_o = ready_q && !flush_stall_i && !rd_block;
   assign take       = cq_valid_i && cq_ready_o;
   assign rd_hit     = take && sop && hdr_rd1;
   assign wr_beat    = take && (sop ? hdr_wr : wr_pkt_q);

   // packet tracking
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q <= 1'b0;
         wr_pkt_q <= 1'b0;
      end else if (take) begin
         in_pkt_q <= !cq_beat_i.last;
         wr_pkt_q <= !cq_beat_i.last && (sop ? hdr_wr : wr_pkt_q);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read FSM, owns ready
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q     <= st_idle;
         ready_q     <= 1'b1;
         req_compl_o <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               if (rd_hit) begin
                  state_q     <= st_rd_wait;
                  ready_q     <= 1'b0;           // stop the stream
                  req_compl_o <= 1'b1;
               end else begin
                  ready_q <= 1'b1;               // reopens one cycle after done
               end
            end
            st_rd_wait: begin
               if (compl_done_i) begin
                  state_q     <= st_idle;
                  req_compl_o <= 1'b0;
               end
            end
         endcase
      end
   end

   // captured read fields
   always_ff @(posedge clk) begin
      if (rd_hit) begin
         rd_req_o.tc   <= cq_beat_i.data[pcie_cq_pkg::tc_lsb +: pcie_cq_pkg::tc_w];
         rd_req_o.attr <= cq_beat_i.data[pcie_cq_pkg::attr_lsb +: pcie_cq_pkg::attr_w];
         rd_req_o.len  <= hdr_len;
         rd_req_o.rid  <= cq_beat_i.data[pcie_cq_pkg::rid_lsb +: pcie_cq_pkg::rid_w];
         rd_req_o.tag  <= cq_beat_i.data[pcie_cq_pkg::tag_lsb +: pcie_cq_pkg::tag_w];
         rd_req_o.be   <= cq_beat_i.first_be;
         rd_req_o.addr <= cq_beat_i.data[pcie_cq_pkg::addr_lsb +: pcie_cq_pkg::addr_w];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // write events
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_evt_valid_o <= 1'b0;
         drain_q        <= 1'b0;
      end else begin
         wr_evt_valid_o <= wr_beat;
         drain_q        <= flush_stall_i;  // flush word goes out next cycle
      end
   end

   always_ff @(posedge clk) begin
      if (wr_beat) begin
         wr_evt_o.start <= sop;
         wr_evt_o.len   <= hdr_len;         // meaningless on payload beats
         wr_evt_o.data  <= cq_beat_i.data;
      end
   end

endmodule

// ==== rtl/cq_write_packer.sv ====
// write payload packer
// joins the held upper half of one beat with the lower half of the next
// into 256-bit FIFO words, DW 0 in the low bits
// zero fill past the packet end, last flag on the final word
// short packets straight from the header beat, flush word for leftovers

`timescale 1ns/100ps

module cq_write_packer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    wr_evt_valid_i,
   input  pcie_cq_pkg::wr_evt_t    wr_evt_i,
   output logic                    fifo_we_o,
   output pcie_cq_pkg::fifo_word_t fifo_word_o,
   output logic                    flush_stall_o
);

   logic [pcie_cq_pkg::len_w-1:0]  rem_q;    // DWs not yet written out
   logic [pcie_cq_pkg::half_w-1:0] hold_q;   // upper half of the previous beat

   logic                           hdr_evt;
   logic                           dat_evt;
   logic                           short_pkt;
   logic                           rem_gt_beat;
   logic                           rem_ends;
   logic                           flush_now;
   logic [pcie_cq_pkg::half_w-1:0] upper;
   logic [pcie_cq_pkg::half_w-1:0] lower;

   // lower n DWs set, n above one word saturates
   function automatic logic [pcie_cq_pkg::cq_data_w-1:0] dw_mask(
      input logic [pcie_cq_pkg::len_w-1:0] n
   );
      logic [pcie_cq_pkg::cq_data_w-1:0] m;
      m = '0;
      for (int i = 0; i < int'(pcie_cq_pkg::beat_dw); i++) begin
         if (int'(n) > i) begin
            m[i*pcie_cq_pkg::dw_w +: pcie_cq_pkg::dw_w] = '1;
         end
      end
      return m;
   endfunction

   assign upper = wr_evt_i.data[pcie_cq_pkg::cq_data_w-1 -: pcie_cq_pkg::half_w];
   assign lower = wr_evt_i.data[pcie_cq_pkg::half_w-1:0];

   assign hdr_evt     = wr_evt_valid_i && wr_evt_i.start;
   assign dat_evt     = wr_evt_valid_i && !wr_evt_i.start && (rem_q != '0);
   assign short_pkt   = wr_evt_i.len <= pcie_cq_pkg::head_dw;  // fits the header beat
   assign rem_gt_beat = rem_q > pcie_cq_pkg::beat_dw;

   // ending beat, its upper half spills into one more word
   assign rem_ends    = rem_gt_beat &&
                        (rem_q <= pcie_cq_pkg::beat_dw + pcie_cq_pkg::head_dw);
   assign flush_now   = (rem_q != '0) && (rem_q <= pcie_cq_pkg::head_dw);

   assign flush_stall_o = dat_evt && rem_ends;

   ////////////////////////////////////////////////////////////////////////////
   // remaining count and write strobe
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rem_q     <= '0;
         fifo_we_o <= 1'b0;
      end else begin
         fifo_we_o <= 1'b0;
         if (hdr_evt) begin
            fifo_we_o <= short_pkt;
            rem_q     <= short_pkt ? '0 : wr_evt_i.len;
         end else if (dat_evt) begin
            fifo_we_o <= 1'b1;
            rem_q     <= rem_gt_beat ? rem_q - pcie_cq_pkg::beat_dw : '0;
         end else if (flush_now) begin
            fifo_we_o <= 1'b1;                 // leftover upper half
            rem_q     <= '0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // word assembly
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (hdr_evt) begin
         hold_q           <= upper;            // DW 0..3
         fifo_word_o.data <= {{pcie_cq_pkg::half_w{1'b0}}, upper} & dw_mask(wr_evt_i.len);
         fifo_word_o.last <= 1'b1;
      end else if (dat_evt) begin
         hold_q           <= upper;
         fifo_word_o.data <= {lower, hold_q} & dw_mask(rem_q);
         fifo_word_o.last <= !rem_gt_beat;
      end else if (flush_now) begin
         fifo_word_o.data <= {{pcie_cq_pkg::half_w{1'b0}}, hold_q} & dw_mask(rem_q);
         fifo_word_o.last <= 1'b1;
      end
   end

endmodule

// ==== rtl/throughput_monitor.sv ====
// throughput monitor
// window counter wrapping every window_cycles clocks
// FIFO word counter restarted at each wrap
// shift register history of finished window counts, newest in entry 0

`timescale 1ns/100ps

module throughput_monitor #(
   parameter int window_cycles = rx_monitor_pkg::window_cycles_default
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     clear_i,
   input  logic                     sample_en_i,
   input  logic                     fifo_we_i,
   output rx_monitor_pkg::tp_hist_t tp_hist_o
);

   logic [rx_monitor_pkg::count_w-1:0] win_q;  // cycles into the window
   logic [rx_monitor_pkg::count_w-1:0] cnt_q;  // words in this window
   logic                               wrap;

   assign wrap = win_q == rx_monitor_pkg::count_w'(window_cycles - 1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_q <= '0;
      end else if (clear_i) begin
         win_q <= '0;
      end else if (wrap) begin
         win_q <= '0;
      end else begin
         win_q <= win_q + 1'b1;
      end
   end

   // a write on the wrap cycle counts toward the new window
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q <= '0;
      end else if (clear_i) begin
         cnt_q <= '0;
      end else if (wrap) begin
         cnt_q <= {{(rx_monitor_pkg::count_w-1){1'b0}}, fifo_we_i};
      end else if (fifo_we_i) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // history
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tp_hist_o <= '0;
      end else if (clear_i) begin
         tp_hist_o <= '0;
      end else if (wrap && sample_en_i) begin
         tp_hist_o <= {tp_hist_o[rx_monitor_pkg::hist_depth-2:0], cnt_q};  // oldest drops
      end
   end

endmodule

// ==== rtl/rx_engine_top.sv ====
// completer-request receive engine top level
// request decoder, write packer and throughput monitor

`timescale 1ns/100ps

module rx_engine_top #(
   parameter int window_cycles = rx_monitor_pkg::window_cycles_default
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cq_valid_i,
   input  pcie_cq_pkg::cq_beat_t    cq_beat_i,
   input  logic                     compl_done_i,
   input  logic                     tp_clear_i,
   input  logic                     tp_sample_en_i,
   output logic                     cq_ready_o,
   output logic                     req_compl_o,
   output pcie_cq_pkg::rd_req_t     rd_req_o,
   output logic                     fifo_we_o,
   output pcie_cq_pkg::fifo_word_t  fifo_word_o,
   output rx_monitor_pkg::tp_hist_t tp_hist_o
);

   logic                 wr_evt_valid;
   pcie_cq_pkg::wr_evt_t wr_evt;
   logic                 flush_stall;   // packer holds the stream one cycle

   cq_request_decoder u_decoder (
      .clk            (clk),
      .rst_n          (rst_n),
      .cq_valid_i     (cq_valid_i),
      .cq_beat_i      (cq_beat_i),
      .compl_done_i   (compl_done_i),
      .flush_stall_i  (flush_stall),
      .cq_ready_o     (cq_ready_o),
      .req_compl_o    (req_compl_o),
      .rd_req_o       (rd_req_o),
      .wr_evt_valid_o (wr_evt_valid),
      .wr_evt_o       (wr_evt)
   );

   cq_write_packer u_packer (
      .clk            (clk),
      .rst_n          (rst_n),
      .wr_evt_valid_i (wr_evt_valid),
      .wr_evt_i       (wr_evt),
      .fifo_we_o      (fifo_we_o),
      .fifo_word_o    (fifo_word_o),
      .flush_stall_o  (flush_stall)
   );

   // counts packed FIFO words
   throughput_monitor #(
      .window_cycles (window_cycles)
   ) u_monitor (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear_i     (tp_clear_i),
      .sample_en_i (tp_sample_en_i),
      .fifo_we_i   (fifo_we_o),
      .tp_hist_o   (tp_hist_o)
   );

endmodule

// ==== tests/rx_engine_assert.sv ====
// concurrent checks bound to the receive engine top level
// stream closed while a completion is pending
// no FIFO write rising together with a new request
// request held until the transmit side reports done

`timescale 1ns/100ps

module rx_engine_assert (
   input logic clk,
   input logic rst_n,
   input logic ready_i,
   input logic req_compl_i,
   input logic compl_done_i,
   input logic fifo_we_i
);

   // read in flight, stream must stay held
   ready_low_a : assert property (@(posedge clk) disable iff (!rst_n)
      req_compl_i |-> !ready_i)
      else $error("cq_ready_o high while req_compl_o is set");

   strobe_apart_a : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(fifo_we_i) |-> !$rose(req_compl_i))
      else $error("fifo_we_o and req_compl_o rose in the same cycle");

   // drops only after done
   compl_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
      (req_compl_i && !compl_done_i) |=> req_compl_i)
      else $error("req_compl_o dropped before compl_done_i");

endmodule

// ==== tests/rx_engine_tb.sv ====
// testbench for the completer-request receive engine
// clock, reset, LCG stimulus and typed compare tasks
// directed tests for reads, short and long writes, ignored requests, throughput
// watchdog and final verdict

`timescale 1ns/100ps

module rx_engine_tb;

   localparam int clk_period     = 40;
   localparam int window         = 64;    // monitor window for this run
   localparam int n_tests        = 6;
   localparam int longest_cycles = 600;   // throughput test, three windows plus drain
   localparam int wait_limit     = 200;   // cycles allowed for any handshake

   logic                     clk = 1'b0;
   logic                     rst_n;
   logic                     cq_valid;
   pcie_cq_pkg::cq_beat_t    cq_beat;
   logic                     compl_done;
   logic                     tp_clear;
   logic                     tp_sample_en;
   logic                     cq_ready;
   logic                     req_compl;
   pcie_cq_pkg::rd_req_t     rd_req;
   logic                     fifo_we;
   pcie_cq_pkg::fifo_word_t  fifo_word;
   rx_monitor_pkg::tp_hist_t tp_hist;

   logic [31:0]              lcg_q = 32'd86032;
   int                       edge_cnt = 0;   // rising edges seen by the test sequence
   pcie_cq_pkg::fifo_word_t  rx_q[$];        // words seen on the FIFO port
   pcie_cq_pkg::fifo_word_t  exp_q[$];       // words the packing rule predicts

   always #(clk_period / 2) clk = ~clk;

   rx_engine_top #(.window_cycles(window)) dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .cq_valid_i     (cq_valid),
      .cq_beat_i      (cq_beat),
      .compl_done_i   (compl_done),
      .tp_clear_i     (tp_clear),
      .tp_sample_en_i (tp_sample_en),
      .cq_ready_o     (cq_ready),
      .req_compl_o    (req_compl),
      .rd_req_o       (rd_req),
      .fifo_we_o      (fifo_we),
      .fifo_word_o    (fifo_word),
      .tp_hist_o      (tp_hist)
   );

   bind rx_engine_top rx_engine_assert u_assert (
      .clk          (clk),
      .rst_n        (rst_n),
      .ready_i      (cq_ready_o),
      .req_compl_i  (req_compl_o),
      .compl_done_i (compl_done_i),
      .fifo_we_i    (fifo_we_o)
   );

   // FIFO port sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n && fifo_we) begin
         rx_q.push_back(fifo_word);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] next_rand();
      lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
      return lcg_q;
   endfunction

   function automatic pcie_cq_pkg::rd_req_t rand_fields(input int len);
      pcie_cq_pkg::rd_req_t f;
      logic [31:0]          r0;
      logic [31:0]          r1;
      r0     = next_rand();
      r1     = next_rand();
      f.tc   = r0[2:0];
      f.attr = r0[5:3];
      f.len  = pcie_cq_pkg::len_w'(len);
      f.rid  = r0[31:16];
      f.tag  = r1[7:0];
      f.be   = r1[15:8];
      f.addr = r1[26:16];
      return f;
   endfunction

   // header half of a first beat
   function automatic logic [pcie_cq_pkg::half_w-1:0] make_header(
      input logic [3:0]           typ,
      input pcie_cq_pkg::rd_req_t f
   );
      logic [pcie_cq_pkg::half_w-1:0] h;
      h = '0;
      h[pcie_cq_pkg::addr_lsb +: pcie_cq_pkg::addr_w] = f.addr;
      h[pcie_cq_pkg::len_lsb +: pcie_cq_pkg::len_w]   = f.len;
      h[pcie_cq_pkg::type_lsb +: 4]                   = typ;
      h[pcie_cq_pkg::rid_lsb +: 16]                   = f.rid;
      h[pcie_cq_pkg::tag_lsb +: 8]                    = f.tag;
      h[pcie_cq_pkg::tc_lsb +: 3]                     = f.tc;
      h[pcie_cq_pkg::attr_lsb +: 3]                   = f.attr;
      return h;
   endfunction

   function automatic pcie_cq_pkg::cq_beat_t rand_beat(input logic last, input logic [7:0] be);
      pcie_cq_pkg::cq_beat_t b;
      for (int j = 0; j < 8; j++) begin
         b.data[32*j +: 32] = next_rand();   // junk where no payload lands
      end
      b.last     = last;
      b.first_be = be;
      return b;
   endfunction

   task automatic step();
      @(posedge clk);
      edge_cnt++;
   endtask

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic compare_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_fail($sformatf("Fail at %0t: %s expected %0b got %0b", $time, what, exp, got));
      end
   endtask

   task automatic compare_fifo_word(
      input pcie_cq_pkg::fifo_word_t got,
      input pcie_cq_pkg::fifo_word_t exp,
      input string                   what
   );
      if (got !== exp) begin
         report_fail($sformatf("Fail at %0t: %s expected %h got %h", $time, what, exp, got));
      end
   endtask

   task automatic compare_rd_req(
      input pcie_cq_pkg::rd_req_t got,
      input pcie_cq_pkg::rd_req_t exp,
      input string                what
   );
      if (got !== exp) begin
         report_fail($sformatf("Fail at %0t: %s expected %h got %h", $time, what, exp, got));
      end
   endtask

   task automatic compare_hist(
      input rx_monitor_pkg::tp_hist_t got,
      input rx_monitor_pkg::tp_hist_t exp,
      input string                    what
   );
      if (got !== exp) begin
         report_fail($sformatf("Fail at %0t: %s expected %h got %h", $time, what, exp, got));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stream drive and FIFO check
   ////////////////////////////////////////////////////////////////////////////
   // called on a rising edge, returns on the edge that takes the beat
   task automatic send_beat(input pcie_cq_pkg::cq_beat_t b);
      int waited;
      waited   = 0;
      cq_valid <= 1'b1;
      cq_beat  <= b;
      @(negedge clk);
      while (!cq_ready) begin
         waited++;
         if (waited > wait_limit) begin
            report_fail("cq_ready_o stayed low, beat never accepted");
         end
         step();
         @(negedge clk);
      end
      step();
   endtask

   task automatic send_write(input int n);
      logic [31:0]             pl[$];
      pcie_cq_pkg::fifo_word_t w;
      pcie_cq_pkg::cq_beat_t   b;
      pcie_cq_pkg::rd_req_t    f;
      int                      nwords;
      int                      nbeats;
      int                      idx;
      for (int i = 0; i < n; i++) begin
         pl.push_back(next_rand());
      end
      // DW 8k+j at bits 32j of word k, zero past the end
      nwords = (n + 7) / 8;
      for (int k = 0; k < nwords; k++) begin
         w = '0;
         for (int j = 0; j < 8; j++) begin
            if (8*k + j < n) w.data[32*j +: 32] = pl[8*k + j];
         end
         w.last = (k == nwords - 1);
         exp_q.push_back(w);
      end
      nbeats = (n <= 4) ? 1 : 1 + (n - 4 + 7) / 8;  // 4 DWs in header beat, 8 after
      f      = rand_fields(n);
      for (int bi = 0; bi < nbeats; bi++) begin
         b = rand_beat(bi == nbeats - 1, f.be);
         if (bi == 0) begin
            b.data[pcie_cq_pkg::half_w-1:0] = make_header(pcie_cq_pkg::req_type_wr, f);
            for (int j = 0; j < 4; j++) begin
               if (j < n) b.data[128 + 32*j +: 32] = pl[j];
            end
         end else begin
            for (int j = 0; j < 8; j++) begin
               idx = 4 + 8*(bi - 1) + j;
               if (idx < n) b.data[32*j +: 32] = pl[idx];
            end
         end
         send_beat(b);
      end
   endtask

   task automatic send_other(input logic [3:0] typ, input int len, input int nbeats);
      pcie_cq_pkg::cq_beat_t b;
      for (int i = 0; i < nbeats; i++) begin
         b = rand_beat(i == nbeats - 1, 8'hff);
         if (i == 0) begin
            b.data[pcie_cq_pkg::half_w-1:0] = make_header(typ, rand_fields(len));
         end
         send_beat(b);
      end
   endtask

   task automatic check_words(input string what);
      int waited;
      waited = 0;
      while (rx_q.size() < exp_q.size()) begin
         waited++;
         if (waited > wait_limit) begin
            report_fail($sformatf("FIFO words missing after %s", what));
         end
         step();
      end
      repeat (4) step();   // catch stray words
      if (rx_q.size() != exp_q.size()) begin
         report_fail($sformatf("more FIFO words than expected after %s", what));
      end
      foreach (exp_q[i]) begin
         compare_fifo_word(rx_q[i], exp_q[i], $sformatf("%s word %0d", what, i));
      end
      rx_q.delete();
      exp_q.delete();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_after_reset();
      @(negedge clk);
      compare_bit(cq_ready, 1'b1, "cq_ready_o after reset");
      compare_bit(req_compl, 1'b0, "req_compl_o after reset");
      compare_bit(fifo_we, 1'b0, "fifo_we_o after reset");
      compare_hist(tp_hist, '0, "history after reset");
      step();
   endtask

   task automatic do_read();
      pcie_cq_pkg::rd_req_t  f;
      pcie_cq_pkg::cq_beat_t b;
      int                    delay;
      f = rand_fields(1);
      b = rand_beat(1'b1, f.be);
      b.data[pcie_cq_pkg::half_w-1:0] = make_header(pcie_cq_pkg::req_type_rd, f);
      send_beat(b);
      cq_valid <= 1'b0;
      @(negedge clk);                 // request one cycle after the header
      compare_bit(req_compl, 1'b1, "req_compl_o after read header");
      compare_bit(cq_ready, 1'b0, "cq_ready_o during read");
      compare_rd_req(rd_req, f, "captured read request");
      delay = int'(next_rand() % 32'd8);
      repeat (delay) begin
         step();
         @(negedge clk);
         compare_bit(req_compl, 1'b1, "req_compl_o held until done");
      end
      step();
      compl_done <= 1'b1;
      step();                         // done seen on this edge
      compl_done <= 1'b0;
      @(negedge clk);
      compare_bit(req_compl, 1'b0, "req_compl_o after done");
      compare_bit(cq_ready, 1'b0, "cq_ready_o one cycle after done");
      step();
      @(negedge clk);
      compare_bit(cq_ready, 1'b1, "cq_ready_o reopened after done");
      step();
   endtask

   task automatic test_short_writes();
      for (int n = 1; n <= 4; n++) begin
         send_write(n);
         cq_valid <= 1'b0;
         check_words($sformatf("%0d DW write", n));
      end
   endtask

   task automatic test_long_writes();
      int lens[$];
      lens = '{5, 8, 9, 12, 13, 16, 17, 40};   // edges of the flush rule
      repeat (6) lens.push_back(5 + int'(next_rand() % 32'd36));
      foreach (lens[i]) begin
         send_write(lens[i]);                 // back to back
      end
      do_read();                              // header waits for the drain
      check_words("long writes");
      @(negedge clk);
      compare_bit(cq_ready, 1'b1, "cq_ready_o after writes");
      step();
   endtask

   task automatic test_ignored();
      send_other(pcie_cq_pkg::req_type_rd, 2, 1);   // multi-DW reads not served
      send_other(pcie_cq_pkg::req_type_rd, 5, 1);
      send_other(4'ha, 3, 2);                        // unknown type, payload consumed
      cq_valid <= 1'b0;
      repeat (4) begin
         @(negedge clk);
         compare_bit(req_compl, 1'b0, "req_compl_o for an ignored request");
         step();
      end
      check_words("ignored requests");
      send_write(6);
      cq_valid <= 1'b0;
      check_words("write after ignored requests");
      do_read();
   endtask

   task automatic test_throughput();
      logic [31:0]              k[3];
      rx_monitor_pkg::tp_hist_t exp;
      int                       s;
      tp_clear     <= 1'b1;
      tp_sample_en <= 1'b1;
      step();                               // window counter restarts here
      tp_clear <= 1'b0;
      s = edge_cnt;
      for (int w = 0; w < 3; w++) begin
         k[w] = 32'd1 + next_rand() % 32'd10;
         for (int i = 0; i < int'(k[w]); i++) begin
            send_write(1);                  // one word each, early in the window
         end
         cq_valid <= 1'b0;
         while (edge_cnt - s < window * (w + 1)) step();
      end
      exp    = '0;
      exp[0] = k[2];                        // newest first
      exp[1] = k[1];
      exp[2] = k[0];
      @(negedge clk);
      compare_hist(tp_hist, exp, "history after three windows");
      step();
      tp_sample_en <= 1'b0;
      tp_clear     <= 1'b1;
      step();
      tp_clear <= 1'b0;
      @(negedge clk);
      compare_hist(tp_hist, '0, "history after clear");
      step();
      check_words("throughput traffic");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      rst_n        = 1'b0;
      cq_valid     = 1'b0;
      cq_beat      = '0;
      compl_done   = 1'b0;
      tp_clear     = 1'b0;
      tp_sample_en = 1'b0;
      repeat (2) step();
      rst_n <= 1'b1;
      check_after_reset();
      repeat (3) do_read();
      test_short_writes();
      test_long_writes();
      test_ignored();
      test_throughput();
      $display("Finished with no errors");
      $finish;
   end

   initial begin
      #(n_tests * longest_cycles * clk_period);
      report_fail("watchdog expired, a test did not complete in time");
   end

endmodule

// ==== verilog.f ====
rtl/pcie_cq_pkg.sv
rtl/rx_monitor_pkg.sv
rtl/cq_request_decoder.sv
rtl/cq_write_packer.sv
rtl/throughput_monitor.sv
rtl/rx_engine_top.sv
tests/rx_engine_assert.sv
tests/rx_engine_tb.sv

// ==== Makefile ====
# Verilator build and run for the receive engine testbench

TOP     := rx_engine_tb
OBJ_DIR := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/$(TOP): verilog.f rtl/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)

# pass only when the run prints the pass line
run: $(OBJ_DIR)/$(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
